//--- commit_trace.f
commit_trace_pkg.sv
commit_rec_if.sv
insn_shadow_pipe.sv
shadow_rob.sv
commit_record_stage.sv
trace_ctrl_regs.sv
commit_trace.sv
tb_commit_trace.sv

//--- Bender.yml
package:
  name: commit_trace

sources:
  - commit_trace_pkg.sv
  - commit_rec_if.sv
  - insn_shadow_pipe.sv
  - shadow_rob.sv
  - commit_record_stage.sv
  - trace_ctrl_regs.sv
  - commit_trace.sv
  - target: test
    files:
      - tb_commit_trace.sv

//--- commit_trace_stimulus.txt
# inputs: id_ce rn_ce id_insn push_size free_bank free_id head_bank head_ptr cmt_ce cmt_fire
# cmt_pc cmt_waddr cmt_wdata cmt_reg_we cmt_excp cmt_excp_vect irq_pending cfg_we cfg_addr cfg_wdata
# then check mask and expected next cycle: valid reg_we insn pc waddr wdata excp excp_vect irq rdata
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 83 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 80 0 0 0 0 0 0 0 0 0 0
1 0 00b0011300a00093 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 81 0 0 0 0 0 0 0 0 0 1
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 0 0 0 0 0 0 0 0 0 0
1 0 2222222211111111 2 2 2b 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 0 0 0 0 0 0 0 0 0 0
0 0 0 1 1 1a 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 2 2b 1 3 4040000100 41 beef0002dead0001 3 0 0 5a 0 0 0
3f 3 3 00b0011300a00093 4040000100 41 beef0002dead0001 0 0 0 0
0 0 0 0 0 0 1 13 0 1 200 0 0 0 1 8 ff 0 0 0
7f 1 0 00a0009311111111 200 0 0 1 8 5a 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 c1 0 0 0 0 0 0 0 0 5a 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 80 0 0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 80 0 0 0 0 0 0 0 0 0 3
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 80 0 0 0 0 0 0 0 0 0 3
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 80 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 80 0 0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 2 2b 0 3 300 0 0 3 1 4 0 0 0 0
af 0 0 00b0011300a00093 300 0 0 1 4 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 81 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 80 0 0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0 80 0 0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 80 0 0 0 0 0 0 0 0 0 0

//--- tb_commit_trace.sv
module tb_commit_trace;
   timeunit 1ns;
   timeprecision 1ps;
   import commit_trace_pkg::*;

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 10;
   localparam int MARGIN_CYCLES = 20;
   localparam int NCOL          = 31;
   localparam int MAX_ROWS      = 128;

   logic         clk;
   logic         rst_n;
   logic         id_ce;
   logic         rn_ce;
   logic [63:0]  id_insn;
   logic [1:0]   push_size;
   logic [1:0]   free_bank;
   logic [5:0]   free_id;
   logic [1:0]   head_bank;
   logic [5:0]   head_ptr;
   logic         cmt_ce;
   logic [1:0]   cmt_fire;
   logic [59:0]  cmt_pc;
   logic [9:0]   cmt_waddr;
   logic [63:0]  cmt_wdata;
   logic [1:0]   cmt_reg_we;
   logic         cmt_excp;
   data_t        cmt_excp_vect;
   logic [7:0]   irq_pending;
   logic         cfg_we;
   cfg_addr_t    cfg_addr;
   data_t        cfg_wdata;
   data_t        cfg_rdata;
   logic [1:0]   trace_valid;
   logic [59:0]  trace_pc;
   logic [63:0]  trace_insn;
   logic [1:0]   trace_reg_we;
   logic [9:0]   trace_waddr;
   logic [63:0]  trace_wdata;
   logic         trace_excp;
   data_t        trace_excp_vect;
   logic [7:0]   trace_irq_pending;

   // Flat table, NCOL values per cycle
   logic [63:0]  tbl [MAX_ROWS*NCOL];
   int           n_rows;
   bit           loaded;

   commit_trace dut0 (
      .clk (clk), .rst_n (rst_n), .id_ce (id_ce), .rn_ce (rn_ce), .id_insn (id_insn),
      .push_size (push_size), .free_bank (free_bank), .free_id (free_id),
      .head_bank (head_bank), .head_ptr (head_ptr), .cmt_ce (cmt_ce), .cmt_fire (cmt_fire),
      .cmt_pc (cmt_pc), .cmt_waddr (cmt_waddr), .cmt_wdata (cmt_wdata),
      .cmt_reg_we (cmt_reg_we), .cmt_excp (cmt_excp), .cmt_excp_vect (cmt_excp_vect),
      .irq_pending (irq_pending), .cfg_we (cfg_we), .cfg_addr (cfg_addr),
      .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata), .trace_valid (trace_valid),
      .trace_pc (trace_pc), .trace_insn (trace_insn), .trace_reg_we (trace_reg_we),
      .trace_waddr (trace_waddr), .trace_wdata (trace_wdata), .trace_excp (trace_excp),
      .trace_excp_vect (trace_excp_vect), .trace_irq_pending (trace_irq_pending)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_on_error();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_insn(string name, insn_t exp, insn_t got);
      if (got !== exp)
      begin
         $display("[FAIL] %s expected %h got %h", name, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_pc(string name, pc_t exp, pc_t got);
      if (got !== exp)
      begin
         $display("[FAIL] %s expected %h got %h", name, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_data(string name, data_t exp, data_t got);
      if (got !== exp)
      begin
         $display("[FAIL] %s expected %h got %h", name, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_bits(string name, logic [63:0] exp, logic [63:0] got);
      if (got !== exp)
      begin
         $display("[FAIL] %s expected %h got %h", name, exp, got);
         stop_on_error();
      end
   endtask

   // Tokens led by # start a comment that runs to the end of the line
   task automatic load_stimulus();
      int    fd;
      int    n;
      int    cnt;
      string tok;
      string rest;
      fd  = $fopen("commit_trace_stimulus.txt", "r");
      cnt = 0;
      if (fd == 0)
      begin
         $display("Cannot open the stimulus file commit_trace_stimulus.txt");
         stop_on_error();
      end
      while (!$feof(fd))
      begin
         n = $fscanf(fd, "%s", tok);
         if (n == 1 && tok.substr(0, 0) == "#")
            n = $fgets(rest, fd);
         else if (n == 1)
         begin
            if (cnt >= MAX_ROWS * NCOL)
            begin
               $display("The stimulus file holds more lines than the testbench can store");
               stop_on_error();
            end
            n = $sscanf(tok, "%h", tbl[cnt]);
            cnt++;
         end
      end
      $fclose(fd);
      if (cnt == 0 || cnt % NCOL != 0)
      begin
         $display("The stimulus file is empty or ends in the middle of a line");
         stop_on_error();
      end
      n_rows = cnt / NCOL;
   endtask

   task automatic apply_row(int r);
      int b;
      b = r * NCOL;
      id_ce         <= tbl[b][0];
      rn_ce         <= tbl[b+1][0];
      id_insn       <= tbl[b+2];
      push_size     <= tbl[b+3][1:0];
      free_bank     <= tbl[b+4][1:0];
      free_id       <= tbl[b+5][5:0];
      head_bank     <= tbl[b+6][1:0];
      head_ptr      <= tbl[b+7][5:0];
      cmt_ce        <= tbl[b+8][0];
      cmt_fire      <= tbl[b+9][1:0];
      cmt_pc        <= tbl[b+10][59:0];
      cmt_waddr     <= tbl[b+11][9:0];
      cmt_wdata     <= tbl[b+12];
      cmt_reg_we    <= tbl[b+13][1:0];
      cmt_excp      <= tbl[b+14][0];
      cmt_excp_vect <= tbl[b+15][31:0];
      irq_pending   <= tbl[b+16][7:0];
      cfg_we        <= tbl[b+17][0];
      cfg_addr      <= tbl[b+18][1:0];
      cfg_wdata     <= tbl[b+19][31:0];
   endtask

   // Mask bits: valid, reg_we, insn, pc, write fields, exception, irq, rdata
   task automatic check_row(int r);
      int          b;
      logic [63:0] mask;
      b    = r * NCOL;
      mask = tbl[b+20];
      if (mask[0])
         check_bits("trace_valid", tbl[b+21], {62'd0, trace_valid});
      if (mask[1])
         check_bits("trace_reg_we", tbl[b+22], {62'd0, trace_reg_we});
      for (int l = 0; l < 2; l++)
      begin
         if (mask[2])
            check_insn("trace_insn", tbl[b+23][l*32 +: 32], trace_insn[l*32 +: 32]);
         if (mask[3])
            check_pc("trace_pc", tbl[b+24][l*30 +: 30], trace_pc[l*30 +: 30]);
         if (mask[4])
            check_data("trace_wdata", tbl[b+26][l*32 +: 32], trace_wdata[l*32 +: 32]);
      end
      if (mask[4])
         check_bits("trace_waddr", tbl[b+25], {54'd0, trace_waddr});
      if (mask[5])
      begin
         check_bits("trace_excp", tbl[b+27], {63'd0, trace_excp});
         check_data("trace_excp_vect", tbl[b+28][31:0], trace_excp_vect);
      end
      if (mask[6])
         check_bits("trace_irq_pending", tbl[b+29], {56'd0, trace_irq_pending});
      if (mask[7])
         check_data("cfg_rdata", tbl[b+30][31:0], cfg_rdata);
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      loaded = 1'b0;
      load_stimulus();
      loaded = 1'b1;
      apply_row(0);
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < n_rows; r++)
      begin
         @(posedge clk);
         apply_row(r);
         @(negedge clk);
         if (r > 0)
            check_row(r - 1);
      end
      @(posedge clk);
      @(negedge clk);
      check_row(n_rows - 1);
      $display("sim passed");
      $finish;
   end

   // Watchdog sized from the stimulus length
   initial
   begin
      wait (loaded);
      #((n_rows + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Timeout: the stimulus did not finish within the expected time");
      stop_on_error();
   end

endmodule

//--- commit_trace.sv
module commit_trace
#(
   parameter int P_ISSUE_WIDTH  = 1,
   parameter int P_COMMIT_WIDTH = 1,
   parameter int P_ROB_DEPTH    = 3,
   parameter int NUM_IRQ        = 8
)
(
   input  logic clk,
   input  logic rst_n,
   // Decode side
   input  logic id_ce,
   input  logic rn_ce,
   input  logic [(1 << P_ISSUE_WIDTH)*commit_trace_pkg::INSN_W-1:0] id_insn,
   // ROB push
   input  logic [P_ISSUE_WIDTH:0] push_size,
   input  logic [(1 << P_ISSUE_WIDTH)*P_COMMIT_WIDTH-1:0] free_bank,
   input  logic [(1 << P_ISSUE_WIDTH)*P_ROB_DEPTH-1:0] free_id,
   // ROB heads
   input  logic [(1 << P_COMMIT_WIDTH)*P_COMMIT_WIDTH-1:0] head_bank,
   input  logic [(1 << P_COMMIT_WIDTH)*P_ROB_DEPTH-1:0] head_ptr,
   // Commit
   input  logic cmt_ce,
   input  logic [(1 << P_COMMIT_WIDTH)-1:0] cmt_fire,
   input  logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::PC_W-1:0] cmt_pc,
   input  logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::LRF_AW-1:0] cmt_waddr,
   input  logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::DATA_W-1:0] cmt_wdata,
   input  logic [(1 << P_COMMIT_WIDTH)-1:0] cmt_reg_we,
   input  logic cmt_excp,
   input  commit_trace_pkg::data_t cmt_excp_vect,
   input  logic [NUM_IRQ-1:0] irq_pending,
   // Configuration port
   input  logic cfg_we,
   input  commit_trace_pkg::cfg_addr_t cfg_addr,
   input  commit_trace_pkg::data_t cfg_wdata,
   output commit_trace_pkg::data_t cfg_rdata,
   // Trace records
   output logic [(1 << P_COMMIT_WIDTH)-1:0] trace_valid,
   output logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::PC_W-1:0] trace_pc,
   output logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::INSN_W-1:0] trace_insn,
   output logic [(1 << P_COMMIT_WIDTH)-1:0] trace_reg_we,
   output logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::LRF_AW-1:0] trace_waddr,
   output logic [(1 << P_COMMIT_WIDTH)*commit_trace_pkg::DATA_W-1:0] trace_wdata,
   output logic trace_excp,
   output commit_trace_pkg::data_t trace_excp_vect,
   output logic [NUM_IRQ-1:0] trace_irq_pending
);
   import commit_trace_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;
   localparam int CW = 1 << P_COMMIT_WIDTH;

   insn_t                     id_insn_a    [IW];
   insn_t                     issue_insn   [IW];
   logic [P_COMMIT_WIDTH-1:0] free_bank_a  [IW];
   logic [P_ROB_DEPTH-1:0]    free_id_a    [IW];
   logic [P_COMMIT_WIDTH-1:0] head_bank_a  [CW];
   logic [P_ROB_DEPTH-1:0]    head_ptr_a   [CW];
   insn_t                     cmt_insn     [CW];
   pc_t                       cmt_pc_a     [CW];
   lrf_addr_t                 cmt_waddr_a  [CW];
   data_t                     cmt_wdata_a  [CW];
   logic                      trace_en;

   commit_rec_if #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH), .NUM_IRQ(NUM_IRQ)) rec_if ();

   // Unpack issue lanes
   for (genvar i = 0; i < IW; i++)
   begin : g_issue_lane
      assign id_insn_a[i]   = id_insn[i*INSN_W +: INSN_W];
      assign free_bank_a[i] = free_bank[i*P_COMMIT_WIDTH +: P_COMMIT_WIDTH];
      assign free_id_a[i]   = free_id[i*P_ROB_DEPTH +: P_ROB_DEPTH];
   end

   // Unpack commit inputs, pack trace outputs
   for (genvar c = 0; c < CW; c++)
   begin : g_commit_lane
      assign head_bank_a[c] = head_bank[c*P_COMMIT_WIDTH +: P_COMMIT_WIDTH];
      assign head_ptr_a[c]  = head_ptr[c*P_ROB_DEPTH +: P_ROB_DEPTH];
      assign cmt_pc_a[c]    = cmt_pc[c*PC_W +: PC_W];
      assign cmt_waddr_a[c] = cmt_waddr[c*LRF_AW +: LRF_AW];
      assign cmt_wdata_a[c] = cmt_wdata[c*DATA_W +: DATA_W];

      assign trace_pc[c*PC_W +: PC_W]          = rec_if.pc[c];
      assign trace_insn[c*INSN_W +: INSN_W]    = rec_if.insn[c];
      assign trace_waddr[c*LRF_AW +: LRF_AW]   = rec_if.waddr[c];
      assign trace_wdata[c*DATA_W +: DATA_W]   = rec_if.wdata[c];
   end

   insn_shadow_pipe #(.P_ISSUE_WIDTH(P_ISSUE_WIDTH)) u_shadow_pipe (
      .clk        (clk),
      .id_ce      (id_ce),
      .rn_ce      (rn_ce),
      .id_insn    (id_insn_a),
      .issue_insn (issue_insn)
   );

   shadow_rob #(
      .P_ISSUE_WIDTH  (P_ISSUE_WIDTH),
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH),
      .P_ROB_DEPTH    (P_ROB_DEPTH)
   ) u_shadow_rob (
      .clk        (clk),
      .issue_insn (issue_insn),
      .push_size  (push_size),
      .free_bank  (free_bank_a),
      .free_id    (free_id_a),
      .head_bank  (head_bank_a),
      .head_ptr   (head_ptr_a),
      .cmt_insn   (cmt_insn)
   );

   commit_record_stage #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH), .NUM_IRQ(NUM_IRQ)) u_record (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmt_ce         (cmt_ce),
      .cmt_fire       (cmt_fire),
      .cmt_pc         (cmt_pc_a),
      .cmt_insn       (cmt_insn),
      .cmt_waddr      (cmt_waddr_a),
      .cmt_wdata      (cmt_wdata_a),
      .cmt_reg_we     (cmt_reg_we),
      .cmt_excp       (cmt_excp),
      .cmt_excp_vect  (cmt_excp_vect),
      .irq_pending_in (irq_pending),
      .rec            (rec_if.src)
   );

   trace_ctrl_regs #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH)) u_ctrl_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .rec       (rec_if.mon),
      .trace_en  (trace_en)
   );

   // Trace enable masks the lane qualifiers only
   assign trace_valid       = rec_if.valid & {CW{trace_en}};
   assign trace_reg_we      = rec_if.reg_we & {CW{trace_en}};
   assign trace_excp        = rec_if.excp;
   assign trace_excp_vect   = rec_if.excp_vect;
   assign trace_irq_pending = rec_if.irq_pending;

endmodule

//--- trace_ctrl_regs.sv
module trace_ctrl_regs
#(
   parameter int P_COMMIT_WIDTH = 1
)
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        cfg_we,
   input  commit_trace_pkg::cfg_addr_t cfg_addr,
   input  commit_trace_pkg::data_t     cfg_wdata,
   output commit_trace_pkg::data_t     cfg_rdata,
   commit_rec_if.mon                   rec,
   output logic                        trace_en
);
   import commit_trace_pkg::*;

   localparam int CW = 1 << P_COMMIT_WIDTH;

   logic [CW-1:0]         gated_valid;
   logic                  excp_hit;
   logic [P_COMMIT_WIDTH:0] n_commits;
   data_t                 cnt_commits;
   data_t                 cnt_excps;

   // Only records that reach the trace outputs are counted
   assign gated_valid = rec.valid & {CW{trace_en}};
   assign excp_hit    = rec.excp & gated_valid[0];

   always_comb
   begin
      n_commits = '0;
      for (int i = 0; i < CW; i++)
      begin
         n_commits = n_commits + gated_valid[i];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         trace_en    <= 1'b0;
         cnt_commits <= '0;
         cnt_excps   <= '0;
         cfg_rdata   <= '0;
      end
      else
      begin
         if (cfg_we && cfg_addr == REG_CTRL)
            trace_en <= cfg_wdata[CTRL_EN_BIT];

         // A write to a counter clears it
         if (cfg_we && cfg_addr == REG_COMMITS)
            cnt_commits <= '0;
         else
            cnt_commits <= cnt_commits + data_t'(n_commits);

         if (cfg_we && cfg_addr == REG_EXCPS)
            cnt_excps <= '0;
         else if (excp_hit)
            cnt_excps <= cnt_excps + data_t'(1);

         case (cfg_addr)
            REG_CTRL:    cfg_rdata <= data_t'(trace_en) << CTRL_EN_BIT;
            REG_COMMITS: cfg_rdata <= cnt_commits;
            REG_EXCPS:   cfg_rdata <= cnt_excps;
            default:     cfg_rdata <= '0;
         endcase
      end
   end

endmodule

//--- commit_record_stage.sv
module commit_record_stage
#(
   parameter int P_COMMIT_WIDTH = 1,
   parameter int NUM_IRQ        = 8
)
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          cmt_ce,
   input  logic [(1 << P_COMMIT_WIDTH)-1:0] cmt_fire,
   input  commit_trace_pkg::pc_t         cmt_pc     [(1 << P_COMMIT_WIDTH)],
   input  commit_trace_pkg::insn_t       cmt_insn   [(1 << P_COMMIT_WIDTH)],
   input  commit_trace_pkg::lrf_addr_t   cmt_waddr  [(1 << P_COMMIT_WIDTH)],
   input  commit_trace_pkg::data_t       cmt_wdata  [(1 << P_COMMIT_WIDTH)],
   input  logic [(1 << P_COMMIT_WIDTH)-1:0] cmt_reg_we,
   input  logic                          cmt_excp,
   input  commit_trace_pkg::data_t       cmt_excp_vect,
   input  logic [NUM_IRQ-1:0]            irq_pending_in,
   commit_rec_if.src                     rec
);

   // Pending interrupts as the commit stage saw them
   logic [NUM_IRQ-1:0] irq_s1;

   always_ff @(posedge clk)
   begin
      if (cmt_ce)
      begin
         irq_s1 <= irq_pending_in;
      end
   end

   // Lane qualifiers
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rec.valid  <= '0;
         rec.reg_we <= '0;
      end
      else
      begin
         rec.valid  <= cmt_fire;
         rec.reg_we <= cmt_reg_we;
      end
   end

   // Record payload
   always_ff @(posedge clk)
   begin
      rec.pc          <= cmt_pc;
      rec.insn        <= cmt_insn;
      rec.waddr       <= cmt_waddr;
      rec.wdata       <= cmt_wdata;
      rec.excp        <= cmt_excp;
      rec.excp_vect   <= cmt_excp_vect;
      rec.irq_pending <= irq_s1;
   end

endmodule

//--- shadow_rob.sv
module shadow_rob
#(
   parameter int P_ISSUE_WIDTH  = 1,
   parameter int P_COMMIT_WIDTH = 1,
   parameter int P_ROB_DEPTH    = 3
)
(
   input  logic                          clk,
   input  commit_trace_pkg::insn_t       issue_insn [(1 << P_ISSUE_WIDTH)],
   input  logic [P_ISSUE_WIDTH:0]        push_size,
   input  logic [P_COMMIT_WIDTH-1:0]     free_bank  [(1 << P_ISSUE_WIDTH)],
   input  logic [P_ROB_DEPTH-1:0]        free_id    [(1 << P_ISSUE_WIDTH)],
   input  logic [P_COMMIT_WIDTH-1:0]     head_bank  [(1 << P_COMMIT_WIDTH)],
   input  logic [P_ROB_DEPTH-1:0]        head_ptr   [(1 << P_COMMIT_WIDTH)],
   output commit_trace_pkg::insn_t       cmt_insn   [(1 << P_COMMIT_WIDTH)]
);
   import commit_trace_pkg::*;

   localparam int IW        = 1 << P_ISSUE_WIDTH;
   localparam int CW        = 1 << P_COMMIT_WIDTH;
   localparam int ROB_DEPTH = 1 << P_ROB_DEPTH;

   // One bank per commit lane, indexed the same way as the core's ROB
   insn_t rob_mem [CW][ROB_DEPTH];

   logic [IW-1:0] push_en;

   // Lanes below push_size carry a valid instruction
   for (genvar i = 0; i < IW; i++)
   begin : g_push_en
      assign push_en[i] = (push_size > (P_ISSUE_WIDTH + 1)'(i));
   end

   // The core never hands two lanes the same bank and slot
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < IW; i++)
      begin
         if (push_en[i])
         begin
            rob_mem[free_bank[i]][free_id[i]] <= issue_insn[i];
         end
      end
   end

   // Head read per commit lane, through the lane's own bank pointer
   for (genvar c = 0; c < CW; c++)
   begin : g_head_read
      assign cmt_insn[c] = rob_mem[head_bank[c]][head_ptr[head_bank[c]]];
   end

endmodule

//--- insn_shadow_pipe.sv
module insn_shadow_pipe
#(
   parameter int P_ISSUE_WIDTH = 1
)
(
   input  logic                    clk,
   input  logic                    id_ce,
   input  logic                    rn_ce,
   input  commit_trace_pkg::insn_t id_insn    [(1 << P_ISSUE_WIDTH)],
   output commit_trace_pkg::insn_t issue_insn [(1 << P_ISSUE_WIDTH)]
);
   import commit_trace_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;

   // Copy of the group sitting in rename
   insn_t rn_insn [IW];

   // Decode to rename, follows the core's ID enable
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < IW; i++)
      begin
         if (id_ce)
         begin
            rn_insn[i] <= id_insn[i];
         end
      end
   end

   // Rename to issue, lines up with the ROB push
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < IW; i++)
      begin
         if (rn_ce)
         begin
            issue_insn[i] <= rn_insn[i];
         end
      end
   end

endmodule

//--- commit_rec_if.sv
interface commit_rec_if
#(
   parameter int P_COMMIT_WIDTH = 1,
   parameter int NUM_IRQ        = 8
);
   import commit_trace_pkg::*;

   localparam int CW = 1 << P_COMMIT_WIDTH;

   logic [CW-1:0]      valid;
   logic [CW-1:0]      reg_we;
   pc_t                pc     [CW];
   insn_t              insn   [CW];
   lrf_addr_t          waddr  [CW];
   data_t              wdata  [CW];
   // Exceptions only ever retire on lane 0
   logic               excp;
   data_t              excp_vect;
   logic [NUM_IRQ-1:0] irq_pending;

   modport src (
      output valid, reg_we, pc, insn, waddr, wdata, excp, excp_vect, irq_pending
   );

   modport mon (
      input valid, reg_we, pc, insn, waddr, wdata, excp, excp_vect, irq_pending
   );

endinterface

//--- commit_trace_pkg.sv
package commit_trace_pkg;

   // Field widths
   localparam int INSN_W = 32;
   localparam int PC_W   = 30;
   localparam int LRF_AW = 5;
   localparam int DATA_W = 32;
   localparam int CFG_AW = 2;

   // Raw instruction word as fetched
   typedef logic [INSN_W-1:0] insn_t;

   // Word-aligned PC, byte offset bits dropped
   typedef logic [PC_W-1:0] pc_t;

   // Logical register number
   typedef logic [LRF_AW-1:0] lrf_addr_t;

   // Register write data, also used for the exception vector
   typedef logic [DATA_W-1:0] data_t;

   // Configuration register index
   typedef logic [CFG_AW-1:0] cfg_addr_t;

   // Register map
   localparam cfg_addr_t REG_CTRL    = 2'd0;
   localparam cfg_addr_t REG_COMMITS = 2'd1;
   localparam cfg_addr_t REG_EXCPS   = 2'd2;

   // Trace enable position inside REG_CTRL
   localparam int CTRL_EN_BIT = 0;

endpackage
